//--- Bender.yml
package:
  name: bit_diff

sources:
  - source/bit_diff_pkg.sv
  - source/bit_diff_ctrl_pkg.sv
  - source/bit_diff_ctrl_if.sv
  - source/bit_diff_controller.sv
  - source/bit_diff_shifter.sv
  - source/bit_diff_accumulator.sv
  - source/bit_diff.sv
  - target: test
    files:
      - test/bit_diff_checker.sv
      - test/bit_diff_monitor.sv
      - test/tb_bit_diff.sv

//--- source/bit_diff.sv
// Top level of the bit-difference calculator joining controller, shifter and accumulator

`timescale 1ns/1ps
`default_nettype none

module bit_diff #(
   parameter int WIDTH = bit_diff_pkg::DEFAULT_WIDTH
) (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic                                              go,
   input  logic [WIDTH-1:0]                                  data,
   output logic signed [bit_diff_pkg::result_width(WIDTH)-1:0] result,
   output logic                                              done
);

   ////////////////////////////////////////////////////////////////////////////
   // Control bundle

   // Commands go out from the controller, the last-bit flag and the current
   // bit come back from the shifter
   bit_diff_ctrl_if #(.WIDTH(WIDTH)) ctl ();

   ////////////////////////////////////////////////////////////////////////////
   // Blocks

   // Sequencer, owns the go/done handshake
   bit_diff_controller controller (
      .clk  (clk),
      .rst  (rst),
      .go   (go),
      .done (done),
      .ctl  (ctl.ctrl)
   );

   // Input side, holds the word and counts the bits taken
   bit_diff_shifter #(
      .WIDTH(WIDTH)
   ) shifter (
      .clk  (clk),
      .rst  (rst),
      .data (data),
      .ctl  (ctl.shift)
   );

   // Processing and output side, running difference plus result register
   bit_diff_accumulator #(
      .WIDTH(WIDTH)
   ) accumulator (
      .clk    (clk),
      .rst    (rst),
      .result (result),
      .ctl    (ctl.accum)
   );

endmodule

`default_nettype wire

//--- source/bit_diff_accumulator.sv
// Running signed difference register and the result register behind the output

`timescale 1ns/1ps
`default_nettype none

module bit_diff_accumulator #(
   parameter int WIDTH = 16
) (
   input  logic                                              clk,
   input  logic                                              rst,
   output logic signed [bit_diff_pkg::result_width(WIDTH)-1:0] result,
   bit_diff_ctrl_if.accum                                    ctl
);

   import bit_diff_pkg::*;

   localparam int DIFF_W = result_width(WIDTH);

   typedef logic signed [DIFF_W-1:0] diff_t;

   diff_t diff_r;
   diff_t diff_next;
   diff_t result_r;

   // A 1 bit counts up and a 0 bit counts down
   assign diff_next = ctl.lsb ? diff_r + diff_t'(1) : diff_r - diff_t'(1);

   ////////////////////////////////////////////////////////////////////////////
   // Running difference

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         diff_r <= '0;
      end else if (ctl.load) begin
         diff_r <= '0;
      end else if (ctl.step) begin
         diff_r <= diff_next;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Result register

   // Written from the stepped value rather than diff_r, because capture comes
   // with the final step and diff_r does not hold the last bit yet
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_r <= '0;
      end else if (ctl.capture) begin
         result_r <= diff_next;
      end
   end

   assign result = result_r;

endmodule

`default_nettype wire

//--- source/bit_diff_controller.sv
// Three-state FSM that sequences load, step and capture and drives done

`timescale 1ns/1ps
`default_nettype none

module bit_diff_controller (
   input  logic       clk,
   input  logic       rst,
   input  logic       go,
   output logic       done,
   bit_diff_ctrl_if.ctrl ctl
);

   import bit_diff_ctrl_pkg::*;

   state_t state_r;
   state_t next_state;

   ////////////////////////////////////////////////////////////////////////////
   // State register

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_r <= START;
      end else begin
         state_r <= next_state;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Next state and command decode

   always_comb begin
      // Hold the state and keep every command idle unless a state says otherwise
      next_state  = state_r;
      ctl.load    = 1'b0;
      ctl.step    = 1'b0;
      ctl.capture = 1'b0;

      case (state_r)
         START: begin
            // Keep reloading the datapath so the word present with go is the one taken
            ctl.load = 1'b1;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         COMPUTE: begin
            // One bit per cycle, go has no effect while a run is in flight
            ctl.step = 1'b1;

            // The final step also writes the result register, so result and
            // done become valid on the same edge
            if (ctl.last) begin
               ctl.capture = 1'b1;
               next_state  = RESTART;
            end
         end

         RESTART: begin
            // Same datapath setup as START, the result register is untouched
            ctl.load = 1'b1;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         default: begin
            next_state = START;
         end
      endcase
   end

   // Decoded from the state alone, so an accepted go clears done one cycle
   // later and logic that builds go from done sees no combinational path
   assign done = (state_r == RESTART);

endmodule

`default_nettype wire

//--- source/bit_diff_ctrl_if.sv
// Control and status bundle between the controller, the shifter and the accumulator

`timescale 1ns/1ps
`default_nettype none

interface bit_diff_ctrl_if #(
   parameter int WIDTH = 16
);

   // Commands from the controller
   logic load;
   logic capture;
   logic step;

   // Status from the shifter
   logic last;
   logic lsb;

   // A run needs at least one bit to examine
   if (WIDTH < 1) begin : g_bad_width
      $error("bit_diff_ctrl_if needs WIDTH of at least 1");
   end

   // Sequencer side
   modport ctrl (output load, output step, output capture, input last);

   // Data register and bit counter side
   modport shift (input load, input step, output last, output lsb);

   // Running difference side
   modport accum (input load, input step, input capture, input lsb);

endinterface

`default_nettype wire

//--- source/bit_diff_ctrl_pkg.sv
// Controller state encoding for the bit-difference calculator

`default_nettype none

package bit_diff_ctrl_pkg;

   // START waits for the first go after reset
   // COMPUTE examines one data bit per cycle
   // RESTART holds the result with done high and waits for the next go
   typedef enum logic [1:0] {
      START   = 2'b00,
      COMPUTE = 2'b01,
      RESTART = 2'b10
   } state_t;

endpackage

`default_nettype wire

//--- source/bit_diff_pkg.sv
// Data width default and signed result sizing for the bit-difference calculator

`default_nettype none

package bit_diff_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data width

   // Number of data bits examined per run when the top level keeps its default
   localparam int DEFAULT_WIDTH = 16;

   ////////////////////////////////////////////////////////////////////////////
   // Result sizing

   // The difference ranges from -width (all zeros) to +width (all ones),
   // which is 2*width+1 distinct values including zero
   // A signed vector of this many bits covers that whole range
   function automatic int result_width(input int width);
      int values;
      values = 2 * width + 1;
      return $clog2(values);
   endfunction

endpackage

`default_nettype wire

//--- source/bit_diff_shifter.sv
// Data shift register and bit counter supplying the current bit and the last-bit flag

`timescale 1ns/1ps
`default_nettype none

module bit_diff_shifter #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] data,
   bit_diff_ctrl_if.shift   ctl
);

   // A one-bit word still needs a one-bit counter
   localparam int COUNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

   typedef logic [WIDTH-1:0]   data_t;
   typedef logic [COUNT_W-1:0] count_t;

   // Index of the last bit, the only place the run length is compared
   localparam count_t LAST_INDEX = count_t'(WIDTH - 1);

   data_t  data_r;
   count_t count_r;

   ////////////////////////////////////////////////////////////////////////////
   // Data word

   // Load takes the input word, step moves the next bit into position 0
   always_ff @(posedge clk) begin
      if (ctl.load) begin
         data_r <= data;
      end else if (ctl.step) begin
         data_r <= data_r >> 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bit counter

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_r <= '0;
      end else if (ctl.load) begin
         count_r <= '0;
      end else if (ctl.step) begin
         count_r <= count_r + 1'b1;
      end
   end

   // The bit under examination is always the low bit of the register
   assign ctl.lsb = data_r[0];

   // High while the final bit of the word is being examined
   assign ctl.last = (count_r == LAST_INDEX);

endmodule

`default_nettype wire

//--- tb.f
source/bit_diff_pkg.sv
source/bit_diff_ctrl_pkg.sv
source/bit_diff_ctrl_if.sv
source/bit_diff_controller.sv
source/bit_diff_shifter.sv
source/bit_diff_accumulator.sv
source/bit_diff.sv
test/bit_diff_checker.sv
test/bit_diff_monitor.sv
test/tb_bit_diff.sv

//--- test/bit_diff_checker.sv
// Concurrent assertions on the controller state, commands and done flag

`timescale 1ns/1ps
`default_nettype none

module bit_diff_checker (
   input logic                      clk,
   input logic                      rst,
   input bit_diff_ctrl_pkg::state_t state,
   input logic                      load,
   input logic                      step,
   input logic                      capture,
   input logic                      done
);

   import bit_diff_ctrl_pkg::*;

   // Number of assertion failures, read by the testbench top at the end
   int failures = 0;

   // The edge that writes the result register also enters RESTART
   capture_then_restart: assert property (
      @(posedge clk) disable iff (rst) capture |=> (state == RESTART)
   ) else begin
      failures++;
      $error("capture was not followed by the RESTART state");
   end

   // Reloading and stepping the datapath in one cycle would corrupt the run
   load_step_exclusive: assert property (
      @(posedge clk) disable iff (rst) !(load && step)
   ) else begin
      failures++;
      $error("load and step were high in the same cycle");
   end

   // done is a pure decode of the RESTART state
   done_tracks_state: assert property (
      @(posedge clk) disable iff (rst) done == (state == RESTART)
   ) else begin
      failures++;
      $error("done did not match the RESTART state");
   end

endmodule

`default_nettype wire

//--- test/bit_diff_monitor.sv
// Port monitor that tracks accepted runs, predicts each result and counts errors

`timescale 1ns/1ps
`default_nettype none

module bit_diff_monitor #(
   parameter int WIDTH = bit_diff_pkg::DEFAULT_WIDTH
) (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic                                              go,
   input  logic [WIDTH-1:0]                                  data,
   input  logic signed [bit_diff_pkg::result_width(WIDTH)-1:0] result,
   input  logic                                              done,
   output int                                                run_count,
   output int                                                check_count,
   output int                                                error_count
);

   import bit_diff_pkg::*;

   localparam int RES_W = result_width(WIDTH);

   typedef logic signed [RES_W-1:0] diff_t;

   logic  busy;
   logic  started;
   int    edges;
   diff_t expected;

   // Plain bit count of the accepted word
   function automatic int ones_in_word(input logic [WIDTH-1:0] word);
      int n;
      n = 0;
      for (int b = 0; b < WIDTH; b++) begin
         if (word[b]) begin
            n++;
         end
      end
      return n;
   endfunction

   task automatic expect_value(input string name, input int got, input int want);
      check_count++;
      if (got != want) begin
         error_count++;
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, want);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run tracking

   // Sampled on the rising edge, so every value seen here is the one
   // left by the previous edge
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         busy        = 1'b0;
         started     = 1'b0;
         edges       = 0;
         expected    = '0;
         run_count   = 0;
         check_count = 0;
         error_count = 0;
      end else begin
         if (!started) begin
            // Reset values hold until the first accepted go
            expect_value("done", done, 0);
            expect_value("result", result, 0);
         end else if (busy) begin
            if (done) begin
               run_count++;
               check_count++;
               if (edges != WIDTH) begin
                  error_count++;
                  $display("done rose %0d edges after the accepted go instead of %0d",
                           edges, WIDTH);
               end
               expect_value("result", result, expected);
               busy = 1'b0;
            end else begin
               edges++;
            end
         end else begin
            // Idle after a run, the result must stay put with done high
            expect_value("done", done, 1);
            expect_value("result", result, expected);
         end

         // A go is only taken when no run is in flight
         if (!busy && go) begin
            expected = diff_t'(2 * ones_in_word(data) - WIDTH);
            busy     = 1'b1;
            started  = 1'b1;
            edges    = 0;
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_bit_diff.sv
// Testbench top with clock, reset, LFSR, stimulus table and the loop that applies it

`timescale 1ns/1ps
`default_nettype none

module tb_bit_diff;

   import bit_diff_pkg::*;

   localparam int          WIDTH        = DEFAULT_WIDTH;
   localparam int          RES_W        = result_width(WIDTH);
   localparam int          CLK_PERIOD   = 40;
   localparam logic [31:0] LFSR_SEED    = 32'h65b21c13;
   localparam int          NUM_FIXED    = 5;
   localparam int          NUM_ROWS     = 16;
   localparam int          DONE_TIMEOUT = 4 * WIDTH;

   // Go styles per table row
   localparam int GO_PULSE = 0;
   localparam int GO_EXTRA = 1;
   localparam int GO_HOLD  = 2;

   logic                    clk;
   logic                    rst;
   logic                    go;
   logic [WIDTH-1:0]        data;
   logic signed [RES_W-1:0] result;
   logic                    done;

   logic [WIDTH-1:0] row_data [NUM_ROWS];
   int               row_style [NUM_ROWS];
   logic [31:0]      lfsr;
   logic             timed_out;
   int               run_count;
   int               check_count;
   int               error_count;
   int               assert_count;

   bit_diff #(.WIDTH(WIDTH)) UUT (
      .clk(clk), .rst(rst), .go(go), .data(data), .result(result), .done(done)
   );

   bit_diff_monitor #(.WIDTH(WIDTH)) monitor (
      .clk(clk), .rst(rst), .go(go), .data(data), .result(result), .done(done),
      .run_count(run_count), .check_count(check_count), .error_count(error_count)
   );

   bind bit_diff_controller bit_diff_checker ctrl_checker (
      .clk(clk), .rst(rst), .state(state_r), .load(ctl.load), .step(ctl.step),
      .capture(ctl.capture), .done(done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Right-shifting Galois LFSR, the bit taken is the one about to leave
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'hA3000000;
      end
      return state >> 1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table

   task automatic build_table();
      row_data[0] = '0;
      row_data[1] = '1;
      row_data[2] = {(WIDTH / 2){2'b01}};
      row_data[3] = WIDTH'(1);
      row_data[4] = {{(WIDTH / 2){1'b0}}, {(WIDTH / 2){1'b1}}};
      for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
         for (int b = 0; b < WIDTH; b++) begin
            row_data[r][b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
         end
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         row_style[r] = GO_PULSE;
      end
      // A stray go during a run, and a chain of back-to-back runs
      row_style[2]  = GO_EXTRA;
      row_style[6]  = GO_EXTRA;
      row_style[9]  = GO_HOLD;
      row_style[10] = GO_HOLD;
      row_style[11] = GO_HOLD;
   endtask

   task automatic wait_for_done(input int row, output logic expired);
      int cycles;
      cycles  = 0;
      expired = 1'b0;
      while (!done && cycles < DONE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timeout: done never rose within %0d cycles for row %0d", DONE_TIMEOUT, row);
         expired = 1'b1;
      end
   endtask

   // A held go from the previous row already stands before the accepting edge
   task automatic apply_row(input int i, output logic expired);
      if (!go) begin
         @(negedge clk);
         data = row_data[i];
         go   = 1'b1;
      end
      @(negedge clk);
      if (row_style[i] == GO_HOLD && i + 1 < NUM_ROWS) begin
         data = row_data[i + 1];
      end else begin
         go = 1'b0;
      end
      if (row_style[i] == GO_EXTRA) begin
         repeat (3) @(negedge clk);
         go   = 1'b1;
         data = ~row_data[i];
         @(negedge clk);
         go = 1'b0;
      end
      wait_for_done(i, expired);
      if (!go) begin
         repeat (2) @(negedge clk);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      go        = 1'b0;
      data      = '0;
      timed_out = 1'b0;
      lfsr      = LFSR_SEED;
      build_table();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Idle cycles show the reset outputs before any go
      repeat (3) @(negedge clk);
      for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
         apply_row(i, timed_out);
      end
      repeat (3) @(negedge clk);
      assert_count = UUT.controller.ctrl_checker.failures;
      $display("Runs: %0d of %0d, checks: %0d, errors: %0d, assertion failures: %0d",
               run_count, NUM_ROWS, check_count, error_count, assert_count);
      if (!timed_out && error_count == 0 && assert_count == 0 && run_count == NUM_ROWS) begin
         $display("*** TEST PASSED ***");
      end else begin
         if (run_count != NUM_ROWS) begin
            $display("The monitor did not see one completed run per table row");
         end
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
